//--- design/core_consts.svh
// Core constants
// Data width and register file geometry for the RV32I execute core

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data path width
`define XLEN 32

// integer register file
`define REG_COUNT 32
`define REG_ADDR_W 5

`endif

//--- design/isaPkg.sv
// ISA encoding package
// Major opcodes and immediate formats of the RV32I base set

package isaPkg;

    // major opcode, inst[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011
    } opcodeE;

    // immediate layout selected by the decoder
    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_U = 3'b001,
        IMM_S = 3'b010,
        IMM_B = 3'b011,
        IMM_J = 3'b100,
        IMM_N = 3'b101,
        IMM_R = 3'b111
    } immTypeE;

endpackage

//--- design/ctrlPkg.sv
// Control package
// Micro-control encodings passed from the decoder to the datapath

package ctrlPkg;

    // {funct7[5], funct7[0], funct3}
    typedef enum logic [4:0] {
        ALU_ADD   = 5'b00000,
        ALU_SLL   = 5'b00001,
        ALU_SLT   = 5'b00010,
        ALU_SLTU  = 5'b00011,
        ALU_XOR   = 5'b00100,
        ALU_SRL   = 5'b00101,
        ALU_OR    = 5'b00110,
        ALU_AND   = 5'b00111,
        ALU_SUB   = 5'b10000,
        ALU_SRA   = 5'b10101,
        ALU_COPYB = 5'b11000
    } aluOpE;

    typedef enum logic [2:0] {
        BR_NONE = 3'b000,
        BR_JAL  = 3'b001,
        BR_JALR = 3'b010,
        BR_EQ   = 3'b100,
        BR_NE   = 3'b101,
        BR_LT   = 3'b110,
        BR_GE   = 3'b111
    } branchE;

    typedef enum logic {A_RS1 = 1'b0, A_PC = 1'b1} aSrcE;

    typedef enum logic [1:0] {B_RS2 = 2'b00, B_IMM = 2'b01, B_FOUR = 2'b10} bSrcE;

    // access size and extension, same code as funct3
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } memOpE;

    typedef enum logic [1:0] {ST_RUN = 2'b00, ST_ERROR = 2'b01, ST_HALT = 2'b10} statusE;

endpackage

//--- design/ctrlIf.sv
// Control bundle
// Decoded per-instruction control, from the decoder to the datapath

`timescale 1ns/1ps
`include "core_consts.svh"

interface ctrlIf;
    import ctrlPkg::*;

    logic             regWr;
    aSrcE             aSrc;
    bSrcE             bSrc;
    aluOpE            aluOp;
    branchE           branch;
    logic             memToReg;
    logic             memWr;
    memOpE            memOp;
    statusE           trap;
    logic [`XLEN-1:0] imm;

    modport decoder (output regWr, aSrc, bSrc, aluOp, branch, memToReg, memWr, memOp, trap, imm);
    modport datapath (input regWr, aSrc, bSrc, aluOp, branch, memToReg, memWr, memOp, trap, imm);
endinterface

//--- design/instDecoder.sv
// Instruction decoder
// Turns one RV32I instruction into the control bundle and builds
// its sign-extended immediate. Unknown encodings raise an error trap,
// ebreak and ecall raise a halt trap.

`timescale 1ns/1ps
`include "core_consts.svh"

module instDecoder (
    input logic [`XLEN-1:0] inst,
    ctrlIf.decoder          ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rLegal;
    immTypeE    immType;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // no M extension, only add/sub and srl/sra use funct7[5]
    assign rLegal = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        immType       = IMM_N;
        ctrl.regWr    = 1'b0;
        ctrl.aSrc     = A_RS1;
        ctrl.bSrc     = B_RS2;
        ctrl.aluOp    = ALU_ADD;
        ctrl.branch   = BR_NONE;
        ctrl.memToReg = 1'b0;
        ctrl.memWr    = 1'b0;
        ctrl.memOp    = MEM_B;
        ctrl.trap     = ST_RUN;
        case (opcode)
            OPC_OP: begin
                immType = IMM_R;
                if (rLegal) begin
                    ctrl.regWr = 1'b1;
                    ctrl.aluOp = aluOpE'({funct7[5], funct7[0], funct3});
                end else begin
                    ctrl.trap = ST_ERROR;
                end
            end
            OPC_OP_IMM: begin
                immType    = IMM_I;
                ctrl.regWr = 1'b1;
                ctrl.bSrc  = B_IMM;
                // only srai carries funct7[5]
                ctrl.aluOp = aluOpE'((funct3 == 3'b101 && funct7[5]) ?
                                     {2'b10, funct3} : {2'b00, funct3});
            end
            OPC_LOAD: begin
                immType = IMM_I;
                if (funct3 == 3'b011 || funct3[2:1] == 2'b11) begin
                    ctrl.trap = ST_ERROR;
                end else begin
                    ctrl.regWr    = 1'b1;
                    ctrl.bSrc     = B_IMM;
                    ctrl.memToReg = 1'b1;
                    ctrl.memOp    = memOpE'(funct3);
                end
            end
            OPC_STORE: begin
                immType = IMM_S;
                if (funct3[2] || funct3 == 3'b011) begin
                    ctrl.trap = ST_ERROR;
                end else begin
                    ctrl.memWr = 1'b1;
                    ctrl.bSrc  = B_IMM;
                    ctrl.memOp = memOpE'(funct3);
                end
            end
            OPC_BRANCH: begin
                immType = IMM_B;
                // funct3[1] marks the unsigned compares
                ctrl.aluOp = funct3[1] ? ALU_SLTU : ALU_SLT;
                case (funct3)
                    3'b000:         ctrl.branch = BR_EQ;
                    3'b001:         ctrl.branch = BR_NE;
                    3'b100, 3'b110: ctrl.branch = BR_LT;
                    3'b101, 3'b111: ctrl.branch = BR_GE;
                    default:        ctrl.trap   = ST_ERROR;
                endcase
            end
            OPC_LUI, OPC_AUIPC: begin
                immType    = IMM_U;
                ctrl.regWr = 1'b1;
                ctrl.aSrc  = A_PC;
                ctrl.bSrc  = B_IMM;
                ctrl.aluOp = (opcode == OPC_LUI) ? ALU_COPYB : ALU_ADD;
            end
            OPC_JAL, OPC_JALR: begin
                // link value pc + 4 comes out of the ALU
                immType     = (opcode == OPC_JAL) ? IMM_J : IMM_I;
                ctrl.regWr  = 1'b1;
                ctrl.aSrc   = A_PC;
                ctrl.bSrc   = B_FOUR;
                ctrl.branch = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
            end
            OPC_SYSTEM: begin
                immType = IMM_I;
                // ecall or ebreak only, everything else is unsupported
                if (inst[31:21] == '0 && inst[19:7] == '0) begin
                    ctrl.trap = ST_HALT;
                end else begin
                    ctrl.trap = ST_ERROR;
                end
            end
            default: ctrl.trap = ST_ERROR;
        endcase
    end

    always_comb begin
        case (immType)
            IMM_I:   ctrl.imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            IMM_S:   ctrl.imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B:   ctrl.imm = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U:   ctrl.imm = {inst[31:12], 12'b0};
            IMM_J:   ctrl.imm = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: ctrl.imm = '0;
        endcase
    end

    // a store never writes a register, whatever the opcode path
    always_comb begin
        assert (!(ctrl.memWr && ctrl.regWr))
            else $error("decoder drives memWr and regWr together");
    end

endmodule

//--- design/aluUnit.sv
// ALU
// RV32I arithmetic, logic, shifts and set-less-than.
// Flags always describe a - b, for the branch decision outside.

`timescale 1ns/1ps
`include "core_consts.svh"

module aluUnit (
    input  ctrlPkg::aluOpE    op,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    output logic [`XLEN-1:0]  result,
    output logic              zero,
    output logic              lessSigned,
    output logic              lessUnsigned
);
    import ctrlPkg::*;

    logic [`XLEN:0]   diff;
    logic [4:0]       shamt;

    // one subtractor feeds sub, the compares and the flags
    assign diff  = {1'b0, a} - {1'b0, b};
    assign shamt = b[4:0];

    assign zero         = (diff[`XLEN-1:0] == '0);
    assign lessUnsigned = diff[`XLEN];
    // signs differ: a is less when a is negative
    assign lessSigned   = (a[`XLEN-1] ^ b[`XLEN-1]) ? a[`XLEN-1] : diff[`XLEN-1];

    always_comb begin
        case (op)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = diff[`XLEN-1:0];
            ALU_SLL:   result = a << shamt;
            ALU_SRL:   result = a >> shamt;
            ALU_SRA:   result = $signed(a) >>> shamt;
            ALU_SLT:   result = {{(`XLEN-1){1'b0}}, lessSigned};
            ALU_SLTU:  result = {{(`XLEN-1){1'b0}}, lessUnsigned};
            ALU_XOR:   result = a ^ b;
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            // lui passes the U immediate straight through
            ALU_COPYB: result = b;
            default:   result = '0;
        endcase
    end

endmodule

//--- design/regFile.sv
// Register file
// 32 x 32-bit integer registers, two combinational reads, one write.
// x0 is never written and always reads zero.

`timescale 1ns/1ps
`include "core_consts.svh"

module regFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    input  logic [`REG_ADDR_W-1:0] wrAddr,
    input  logic                   wrEn,
    input  logic [`XLEN-1:0]       wrData,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    x0Zero: assert property (@(posedge clk) disable iff (!arstN) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

//--- design/execCore.sv
// RV32I execute core
// Single-cycle decode, register read, ALU, branch resolution, load
// extension and writeback. Holds the halt/error status until reset.

`timescale 1ns/1ps
`include "core_consts.svh"

module execCore (
    input  logic              clk,
    input  logic              arstN,
    input  logic              instValid,
    input  logic [`XLEN-1:0]  inst,
    input  logic [`XLEN-1:0]  pc,
    input  logic [`XLEN-1:0]  loadData,
    output logic [`XLEN-1:0]  nextPc,
    output logic              memWr,
    output logic [`XLEN-1:0]  memAddr,
    output logic [`XLEN-1:0]  memWdata,
    output ctrlPkg::memOpE    memOp,
    output logic                   wbEn,
    output logic [`REG_ADDR_W-1:0] wbRd,
    output logic [`XLEN-1:0]       wbData,
    output ctrlPkg::statusE        status
);
    import ctrlPkg::*;

    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] loadExt;
    logic             zero;
    logic             lessSigned;
    logic             lessUnsigned;
    logic             less;
    logic             taken;
    logic             active;

    ctrlIf ctrl ();

    instDecoder decoderU (.inst(inst), .ctrl(ctrl.decoder));

    regFile regFileU (
        .clk(clk), .arstN(arstN),
        .rs1Addr(inst[19:15]), .rs2Addr(inst[24:20]),
        .wrAddr(wbRd), .wrEn(wbEn), .wrData(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    aluUnit aluU (
        .op(ctrl.aluOp), .a(opA), .b(opB), .result(aluResult),
        .zero(zero), .lessSigned(lessSigned), .lessUnsigned(lessUnsigned)
    );

    // nothing commits once the core has stopped
    assign active = instValid && (status == ST_RUN);

    assign opA = (ctrl.aSrc == A_PC) ? pc : rs1Data;
    always_comb begin
        case (ctrl.bSrc)
            B_IMM:   opB = ctrl.imm;
            B_FOUR:  opB = `XLEN'(4);
            default: opB = rs2Data;
        endcase
    end

    // unsigned branches are decoded with the sltu op
    assign less = (ctrl.aluOp == ALU_SLTU) ? lessUnsigned : lessSigned;
    always_comb begin
        case (ctrl.branch)
            BR_EQ:   taken = zero;
            BR_NE:   taken = !zero;
            BR_LT:   taken = less;
            BR_GE:   taken = !less;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (!active) begin
            nextPc = pc;
        end else if (ctrl.branch == BR_JAL || taken) begin
            nextPc = pc + ctrl.imm;
        end else if (ctrl.branch == BR_JALR) begin
            nextPc = (rs1Data + ctrl.imm) & ~`XLEN'(1);
        end else begin
            nextPc = pc + `XLEN'(4);
        end
    end

    // load data arrives right-aligned
    always_comb begin
        case (ctrl.memOp)
            MEM_B:   loadExt = {{(`XLEN-8){loadData[7]}}, loadData[7:0]};
            MEM_H:   loadExt = {{(`XLEN-16){loadData[15]}}, loadData[15:0]};
            MEM_BU:  loadExt = {{(`XLEN-8){1'b0}}, loadData[7:0]};
            MEM_HU:  loadExt = {{(`XLEN-16){1'b0}}, loadData[15:0]};
            default: loadExt = loadData;
        endcase
    end

    assign memWr    = active && ctrl.memWr;
    assign memAddr  = aluResult;
    assign memWdata = rs2Data;
    assign memOp    = ctrl.memOp;

    assign wbRd   = inst[11:7];
    assign wbEn   = active && ctrl.regWr && (wbRd != '0);
    assign wbData = ctrl.memToReg ? loadExt : aluResult;

    // sticky until reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            status <= ST_RUN;
        end else if (active && ctrl.trap != ST_RUN) begin
            status <= ctrl.trap;
        end
    end

    // the reported writeback must land in the register file
    wbLands: assert property (@(posedge clk) disable iff (!arstN)
        wbEn |=> regFileU.regs[$past(wbRd)] == $past(wbData))
        else $error("reported writeback did not land in the register file");

endmodule

//--- verification/tbClock.sv
// Testbench clock and reset
// Free-running clock and a power-on reset held low for a number of cycles

`timescale 1ns/1ps

module tbClock #(
    parameter int clkPeriod   = 8,
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic arstN
);
    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // release just after an edge, away from the sampling point
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
    end

endmodule

//--- verification/coreChecker.sv
// Execute core checker
// Compares the DUT ports against the expected record of each step,
// applies the idle rules between steps and counts the errors

`timescale 1ns/1ps

module coreChecker (
    input  logic        clk,
    input  logic        arstN,
    input  logic        instValid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic [31:0] nextPc,
    input  logic        memWr,
    input  logic [31:0] memAddr,
    input  logic [31:0] memWdata,
    input  logic [2:0]  memOp,
    input  logic        wbEn,
    input  logic [4:0]  wbRd,
    input  logic [31:0] wbData,
    input  logic [1:0]  status,
    input  logic        expValid,
    input  logic [31:0] expRec [12],
    output int          errCount,
    output int          checkCount
);
    // record columns, same order as the pattern file
    localparam int colFlags    = 0;
    localparam int colNextPc   = 4;
    localparam int colWbEn     = 5;
    localparam int colWbRd     = 6;
    localparam int colWbData   = 7;
    localparam int colMemWr    = 8;
    localparam int colMemAddr  = 9;
    localparam int colMemWdata = 10;
    localparam int colStatus   = 11;

    int         errors     = 0;
    int         checks     = 0;
    logic       statusPend = 1'b0;
    logic [1:0] pendStatus = 2'b00;

    assign errCount   = errors;
    assign checkCount = checks;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkStep();
        logic [31:0] flags;
        flags = expRec[colFlags];
        checkValue("nextPc", expRec[colNextPc], nextPc);
        checkValue("wbEn", expRec[colWbEn], 32'(wbEn));
        checkValue("memWr", expRec[colMemWr], 32'(memWr));
        if (expRec[colWbEn][0]) begin
            checkValue("wbRd", expRec[colWbRd], 32'(wbRd));
            checkValue("wbData", expRec[colWbData], wbData);
        end
        if (flags[1]) begin
            checkValue("memAddr", expRec[colMemAddr], memAddr);
        end
        if (flags[2]) begin
            checkValue("memWdata", expRec[colMemWdata], memWdata);
        end
        // a store carries funct3 as its access format
        if (expRec[colMemWr][0]) begin
            checkValue("memOp", 32'(inst[14:12]), 32'(memOp));
        end
    endtask

    // mid-cycle sampling, inputs change just after the rising edge
    always @(negedge clk) begin
        if (!arstN) begin
            statusPend = 1'b0;
        end else begin
            // status of a step shows up one edge later
            if (statusPend) begin
                checkValue("status", 32'(pendStatus), 32'(status));
            end
            statusPend = 1'b0;
            if (expValid) begin
                checkStep();
                pendStatus = expRec[colStatus][1:0];
                statusPend = 1'b1;
            end else if (!instValid) begin
                checkValue("memWr", 32'd0, 32'(memWr));
                checkValue("wbEn", 32'd0, 32'(wbEn));
                checkValue("nextPc", pc, nextPc);
            end
        end
    end

endmodule

//--- verification/execCore_tb.sv
// Execute core testbench
// Replays the pattern file one step per valid cycle, with random idle
// gaps in between, and hands each expected record to the checker

`timescale 1ns/1ps

module execCore_tb;
    import ctrlPkg::*;

    localparam int    clkPeriod    = 8;
    localparam int    wordsPerStep = 12;
    localparam int    maxSteps     = 48;
    localparam int    idleBudget   = 32;
    localparam string patFile      = "verification/exec_patterns.hex";

    logic            clk;
    logic            baseRstN;
    logic            segRstN;
    logic            arstN;
    logic            instValid;
    logic [31:0]     inst;
    logic [31:0]     pc;
    logic [31:0]     loadData;
    logic [31:0]     nextPc;
    logic            memWr;
    logic [31:0]     memAddr;
    logic [31:0]     memWdata;
    memOpE           memOp;
    logic            wbEn;
    logic [4:0]      wbRd;
    logic [31:0]     wbData;
    statusE          status;

    // expected record of the step on the ports
    logic            expValid;
    logic [31:0]     expRec [wordsPerStep];
    logic [31:0]     patMem [maxSteps * wordsPerStep];
    int              stepCount;
    int              idleUsed;
    bit              loaded;
    int              errCount;
    int              checkCount;

    tbClock #(.clkPeriod(clkPeriod), .resetCycles(10)) clockU (.clk(clk), .arstN(baseRstN));

    // pattern flag can pull reset for a second run segment
    assign arstN = baseRstN && segRstN;

    execCore dut_i (
        .clk(clk), .arstN(arstN), .instValid(instValid), .inst(inst), .pc(pc),
        .loadData(loadData), .nextPc(nextPc), .memWr(memWr), .memAddr(memAddr),
        .memWdata(memWdata), .memOp(memOp), .wbEn(wbEn), .wbRd(wbRd),
        .wbData(wbData), .status(status)
    );

    coreChecker checkU (
        .clk(clk), .arstN(arstN), .instValid(instValid), .inst(inst), .pc(pc),
        .nextPc(nextPc), .memWr(memWr), .memAddr(memAddr), .memWdata(memWdata),
        .memOp(memOp), .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData), .status(status),
        .expValid(expValid), .expRec(expRec), .errCount(errCount), .checkCount(checkCount)
    );

    task automatic runIdle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            instValid = 1'b0;
            expValid  = 1'b0;
        end
    endtask

    task automatic applyStep(input int idx);
        int base;
        base = idx * wordsPerStep;
        @(posedge clk);
        #1;
        for (int k = 0; k < wordsPerStep; k++) begin
            expRec[k] = patMem[base + k];
        end
        inst      = patMem[base + 1];
        pc        = patMem[base + 2];
        loadData  = patMem[base + 3];
        instValid = 1'b1;
        expValid  = 1'b1;
    endtask

    // one idle cycle first so the previous status check still lands
    task automatic pulseReset();
        runIdle(1);
        @(posedge clk);
        #1;
        segRstN = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        segRstN = 1'b1;
    endtask

    // steps end at the first record with flag bit 3
    function automatic int countSteps();
        int n;
        n = 0;
        while (n < maxSteps && patMem[n * wordsPerStep][3] == 1'b0) begin
            n++;
        end
        return n;
    endfunction

    initial begin
        int fd;
        int gap;
        instValid = 1'b0;
        inst      = '0;
        pc        = '0;
        loadData  = '0;
        segRstN   = 1'b1;
        expValid  = 1'b0;
        for (int k = 0; k < wordsPerStep; k++) begin
            expRec[k] = '0;
        end
        loaded   = 1'b0;
        idleUsed = 0;
        void'($urandom(32'ha3ff_98f9));
        fd = $fopen(patFile, "r");
        if (fd != 0) begin
            $fclose(fd);
            $readmemh(patFile, patMem);
            stepCount = countSteps();
        end else begin
            stepCount = 0;
        end
        if (fd == 0 || stepCount == 0 || stepCount == maxSteps) begin
            $display("pattern file %s could not be read or has no end marker", patFile);
            $display("tests failed");
            $finish;
        end else begin
            loaded = 1'b1;
            wait (baseRstN);
            for (int i = 0; i < stepCount; i++) begin
                if (patMem[i * wordsPerStep][0]) begin
                    pulseReset();
                end
                gap = $urandom % 3;
                if (idleUsed + gap > idleBudget) begin
                    gap = 0;
                end
                idleUsed += gap;
                runIdle(gap);
                applyStep(i);
            end
            // let the last status check happen
            runIdle(2);
            $display("checks %0d, errors %0d", checkCount, errCount);
            if (errCount == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

    // watchdog sized from the number of steps
    initial begin
        wait (loaded);
        #((stepCount + idleBudget + 20) * clkPeriod);
        $display("timeout, run did not finish within %0d cycles (checks %0d, errors %0d)",
                 stepCount + idleBudget + 20, checkCount, errCount);
        $display("tests failed");
        $finish;
    end

endmodule

//--- verification/exec_patterns.hex
// flags inst pc loadData nextPc wbEn wbRd wbData memWr memAddr memWdata status
// flags: 1 reset before the step, 2 check memAddr, 4 check memWdata, 8 end of list
0 00500093 00000100 00000000 00000104 1 01 00000005 0 00000000 00000000 0
0 FFD00113 00000104 00000000 00000108 1 02 FFFFFFFD 0 00000000 00000000 0
0 002081B3 00000108 00000000 0000010C 1 03 00000002 0 00000000 00000000 0
0 40208233 0000010C 00000000 00000110 1 04 00000008 0 00000000 00000000 0
0 00409293 00000110 00000000 00000114 1 05 00000050 0 00000000 00000000 0
0 40115313 00000114 00000000 00000118 1 06 FFFFFFFE 0 00000000 00000000 0
0 0020B3B3 00000118 00000000 0000011C 1 07 00000001 0 00000000 00000000 0
0 12345437 0000011C 00000000 00000120 1 08 12345000 0 00000000 00000000 0
0 00708013 00000120 00000000 00000124 0 00 00000000 0 00000000 00000000 0
0 00108463 00000124 00000000 0000012C 0 00 00000000 0 00000000 00000000 0
0 00208463 00000128 00000000 0000012C 0 00 00000000 0 00000000 00000000 0
0 00209463 0000012C 00000000 00000134 0 00 00000000 0 00000000 00000000 0
0 00109463 00000130 00000000 00000134 0 00 00000000 0 00000000 00000000 0
0 00114463 00000134 00000000 0000013C 0 00 00000000 0 00000000 00000000 0
0 0020C463 00000138 00000000 0000013C 0 00 00000000 0 00000000 00000000 0
0 0020D463 0000013C 00000000 00000144 0 00 00000000 0 00000000 00000000 0
0 00115463 00000140 00000000 00000144 0 00 00000000 0 00000000 00000000 0
0 0020E463 00000144 00000000 0000014C 0 00 00000000 0 00000000 00000000 0
0 00116463 00000148 00000000 0000014C 0 00 00000000 0 00000000 00000000 0
0 FE117EE3 0000014C 00000000 00000148 0 00 00000000 0 00000000 00000000 0
0 0020F463 00000150 00000000 00000154 0 00 00000000 0 00000000 00000000 0
0 020004EF 00000154 00000000 00000174 1 09 00000158 0 00000000 00000000 0
0 00608567 00000158 00000000 0000000A 1 0A 0000015C 0 00000000 00000000 0
2 00308583 0000015C CAFE8281 00000160 1 0B FFFFFF81 0 00000008 00000000 0
2 00409603 00000160 CAFE8281 00000164 1 0C FFFF8281 0 00000009 00000000 0
2 FFF0A683 00000164 CAFE8281 00000168 1 0D CAFE8281 0 00000004 00000000 0
2 00014703 00000168 CAFE8281 0000016C 1 0E 00000081 0 FFFFFFFD 00000000 0
2 0020D783 0000016C CAFE8281 00000170 1 0F 00008281 0 00000007 00000000 0
6 0080A623 00000170 00000000 00000174 0 00 00000000 1 00000011 12345000 0
6 FE209F23 00000174 00000000 00000178 0 00 00000000 1 00000003 FFFFFFFD 0
6 00418023 00000178 00000000 0000017C 0 00 00000000 1 00000002 00000008 0
0 00100073 0000017C 00000000 00000180 0 00 00000000 0 00000000 00000000 2
0 00500093 00000180 00000000 00000180 0 00 00000000 0 00000000 00000000 2
1 00008813 00000200 00000000 00000204 1 10 00000000 0 00000000 00000000 0
0 0000007F 00000204 00000000 00000208 0 00 00000000 0 00000000 00000000 1
0 00100293 00000208 00000000 00000208 0 00 00000000 0 00000000 00000000 1
8 00000000 00000000 00000000 00000000 0 00 00000000 0 00000000 00000000 0

//--- tb.f
+incdir+design
design/isaPkg.sv
design/ctrlPkg.sv
design/ctrlIf.sv
design/instDecoder.sv
design/aluUnit.sv
design/regFile.sv
design/execCore.sv
verification/tbClock.sv
verification/coreChecker.sv
verification/execCore_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the execute core testbench with Verilator and runs it.
# The run passes only if the pass line shows up in the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module execCore_tb -f tb.f -o execCoreSim
./obj_dir/execCoreSim | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
